/* run.sh */
#!/bin/sh
# Build and run the SPI subsystem regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_spi_subsystem -f vlog.f -o sim_spi

out=$(./obj_dir/sim_spi || true)
echo "$out"
echo "$out" | grep -q "Regression passed"

/* src/byte_fifo.sv */
`timescale 1ns/1ps

module byte_fifo
    import spi_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_en,
    input  byte_t     wr_data,
    input  logic      rd_en,
    output byte_t     rd_data,   // Oldest entry, show-ahead
    output logic      full,
    output logic      empty,
    output fifo_cnt_t level
);

    // ------------------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------------------
    byte_t     mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;

    logic do_wr;
    logic do_rd;

    // Qualified strobes, callers need not check flags
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // ------------------------------------------------------------
    // Data array
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // ------------------------------------------------------------
    // Pointer update
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Fill count
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end
        else begin
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Idle or both, no change
            endcase
        end
    end

    // ------------------------------------------------------------
    // Flags and read port
    // ------------------------------------------------------------
    assign full    = (count == FIFO_FULL_CNT);
    assign empty   = (count == '0);
    assign level   = count;
    assign rd_data = mem[rd_ptr];   // Stale when empty

endmodule

/* src/spi_master.sv */
`timescale 1ns/1ps

module spi_master
    import spi_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  byte_t tx_byte,     // Head of transmit FIFO
    input  logic  tx_empty,
    input  logic  rx_full,
    input  logic  miso,
    output logic  tx_pop,      // One cycle, in IDLE
    output logic  rx_push,     // One cycle, in DONE
    output byte_t rx_byte,     // Valid with rx_push
    output logic  sclk,
    output logic  mosi,
    output logic  cs_n         // Active low
);

    // ------------------------------------------------------------
    // State and counters
    // ------------------------------------------------------------
    spi_state_t state;
    spi_state_t next_state;

    div_cnt_t div_cnt;         // Half period divider
    bit_cnt_t bit_cnt;         // Bits still to shift
    logic     sclk_int;

    byte_t shft_tx;
    byte_t shft_rx;

    logic half_tick;           // SCLK edge this cycle
    logic fall_tick;           // Leading edge, sample
    logic rise_tick;           // Trailing edge, shift out

    // Start only with data waiting and room for the answer
    assign tx_pop = (state == IDLE) && !tx_empty && !rx_full;

    assign half_tick = (state == XFER) && (div_cnt == DIV_LAST);
    assign fall_tick = half_tick && (sclk_int == SCLK_IDLE);
    assign rise_tick = half_tick && (sclk_int != SCLK_IDLE);

    // ------------------------------------------------------------
    // State register
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end
        else begin
            state <= next_state;
        end
    end

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (tx_pop) begin
                    next_state = LOAD;
                end
            end
            LOAD: next_state = XFER;
            XFER: begin
                // Last rising edge done, clock back at idle level
                if (bit_cnt == '0 && sclk_int == SCLK_IDLE) begin
                    next_state = DONE;
                end
            end
            DONE: next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // ------------------------------------------------------------
    // Divider and SCLK, idle high outside XFER
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt  <= '0;
            sclk_int <= SCLK_IDLE;
        end
        else if (state == XFER) begin
            if (half_tick) begin
                div_cnt  <= '0;
                sclk_int <= ~sclk_int;      // First toggle is falling
            end
            else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
        else begin
            div_cnt  <= '0;
            sclk_int <= SCLK_IDLE;
        end
    end

    // ------------------------------------------------------------
    // Bit counter and mosi
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt <= '0;
            mosi    <= 1'b0;
        end
        else begin
            case (state)
                LOAD: begin
                    bit_cnt <= BIT_LOAD;
                    mosi    <= shft_tx[SPI_BITS-1];   // MSB out early
                end
                XFER: begin
                    if (rise_tick) begin
                        bit_cnt <= bit_cnt - 1'b1;
                        mosi    <= shft_tx[SPI_BITS-2]; // Next bit
                    end
                end
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Shift registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (tx_pop) begin
            shft_tx <= tx_byte;             // Capture FIFO head on pop
        end
        else if (rise_tick) begin
            shft_tx <= {shft_tx[SPI_BITS-2:0], 1'b0};
        end

        // Eight samples fully replace the old byte
        if (fall_tick) begin
            shft_rx <= {shft_rx[SPI_BITS-2:0], miso};
        end
    end

    // ------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------
    assign rx_push = (state == DONE);
    assign rx_byte = shft_rx;
    assign sclk    = sclk_int;
    assign cs_n    = (state != XFER);   // Low only while shifting

endmodule

/* src/spi_pkg.sv */
package spi_pkg;

    // ------------------------------------------------------------
    // Link and buffer sizing
    // ------------------------------------------------------------
    localparam int SPI_DIVIDE = 4;          // Sys clocks per half SCLK
    localparam int SPI_BITS   = 8;          // Bits per transfer
    localparam int FIFO_DEPTH = 8;          // Power of two

    localparam int DIV_W      = $clog2(SPI_DIVIDE);
    localparam int BIT_CNT_W  = $clog2(SPI_BITS + 1);
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1); // Holds 0..DEPTH

    // Mode 2 clock polarity
    localparam logic SCLK_IDLE = 1'b1;

    // ------------------------------------------------------------
    // Widths with a meaning
    // ------------------------------------------------------------
    typedef logic [SPI_BITS-1:0]   byte_t;      // Host and shift data
    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;  // FIFO fill count
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;  // FIFO index, wraps
    typedef logic [DIV_W-1:0]      div_cnt_t;   // Half period counter
    typedef logic [BIT_CNT_W-1:0]  bit_cnt_t;   // Bits left in transfer

    // Typed terminal values
    localparam div_cnt_t  DIV_LAST      = div_cnt_t'(SPI_DIVIDE - 1);
    localparam bit_cnt_t  BIT_LOAD      = bit_cnt_t'(SPI_BITS);
    localparam fifo_cnt_t FIFO_FULL_CNT = fifo_cnt_t'(FIFO_DEPTH);

    // Engine FSM
    typedef enum logic [1:0] {
        IDLE,   // Wait for data and room
        LOAD,   // First bit onto mosi
        XFER,   // cs_n low, sclk running
        DONE    // Push received byte
    } spi_state_t;

endpackage

/* src/spi_subsystem.sv */
`timescale 1ns/1ps

module spi_subsystem
    import spi_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // Host write side
    input  logic      wr_en,
    input  byte_t     wr_data,
    output logic      tx_full,
    // Host read side
    input  logic      rd_en,
    output byte_t     rd_data,
    output logic      rx_empty,
    output fifo_cnt_t rx_level,
    // SPI pins
    input  logic      miso,
    output logic      sclk,
    output logic      mosi,
    output logic      cs_n
);

    // ------------------------------------------------------------
    // Internal links
    // ------------------------------------------------------------
    byte_t tx_head;        // Transmit FIFO head into engine
    logic  tx_empty;
    logic  tx_pop;
    byte_t rx_byte;        // Engine result into receive FIFO
    logic  rx_push;
    logic  rx_full;

    // Host to engine
    byte_fifo i_tx_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (tx_pop),
        .rd_data (tx_head),
        .full    (tx_full),
        .empty   (tx_empty),
        .level   ()
    );

    // Shift engine
    spi_master i_master (
        .clk      (clk),
        .rst      (rst),
        .tx_byte  (tx_head),
        .tx_empty (tx_empty),
        .rx_full  (rx_full),
        .miso     (miso),
        .tx_pop   (tx_pop),
        .rx_push  (rx_push),
        .rx_byte  (rx_byte),
        .sclk     (sclk),
        .mosi     (mosi),
        .cs_n     (cs_n)
    );

    // Engine to host
    byte_fifo i_rx_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (rx_push),
        .wr_data (rx_byte),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .full    (rx_full),
        .empty   (rx_empty),
        .level   (rx_level)
    );

endmodule

/* testbench/spi_slave_model.sv */
`timescale 1ns/1ps

module spi_slave_model
    import spi_pkg::*;
(
    input  logic sclk,
    input  logic mosi,
    input  logic cs_n,
    output logic miso
);

    byte_t resp_q[$];      // Filled by the testbench, one per transfer
    byte_t cap_q[$];       // Completed mosi bytes

    byte_t tx_sh;
    byte_t rx_sh;
    int    bit_cnt;

    initial begin
        miso    = 1'b0;
        tx_sh   = '0;
        rx_sh   = '0;
        bit_cnt = 0;
    end

    // ------------------------------------------------------------
    // Transfer start, first bit out before any clock edge
    // ------------------------------------------------------------
    always @(negedge cs_n) begin
        if (resp_q.size() > 0) begin
            tx_sh = resp_q.pop_front();
        end
        else begin
            tx_sh = '0;            // Unplanned transfer, shows up in captures
        end
        bit_cnt = 0;
        miso    = tx_sh[SPI_BITS-1];
    end

    // Leading edge samples mosi
    always @(negedge sclk) begin
        if (!cs_n) begin
            rx_sh = {rx_sh[SPI_BITS-2:0], mosi};
            bit_cnt++;
            if (bit_cnt == SPI_BITS) begin
                cap_q.push_back(rx_sh);
            end
        end
    end

    // Trailing edge moves to next miso bit
    always @(posedge sclk) begin
        if (!cs_n) begin
            tx_sh = {tx_sh[SPI_BITS-2:0], 1'b0};
            miso  = tx_sh[SPI_BITS-1];
        end
    end

endmodule

/* testbench/spi_subsystem_assert.sv */
`timescale 1ns/1ps

module spi_subsystem_assert
    import spi_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input spi_state_t state,
    input logic       tx_pop,
    input logic       tx_empty,
    input logic       rx_full,
    input logic       rx_push,
    input logic       sclk,
    input logic       cs_n
);

    // Slave select only while shifting
    a_cs_xfer_only: assert property (@(posedge clk) disable iff (rst)
        (state != XFER) |-> cs_n)
        else $error("cs_n low outside XFER");

    // Mode 2, clock parked high when deselected
    a_sclk_idle: assert property (@(posedge clk) disable iff (rst)
        cs_n |-> sclk)
        else $error("sclk low while cs_n high");

    a_pop_legal: assert property (@(posedge clk) disable iff (rst)
        tx_pop |-> (state == IDLE && !tx_empty && !rx_full))
        else $error("tx_pop outside IDLE or without data and room");

    a_pop_push_apart: assert property (@(posedge clk) disable iff (rst)
        !(tx_pop && rx_push))
        else $error("tx_pop and rx_push together");

endmodule

/* testbench/tb_spi_subsystem.sv */
`timescale 1ns/1ps

module tb_spi_subsystem
    import spi_pkg::*;
();

    localparam int WAIT_LIMIT   = 4000;   // Cycles per wait loop
    localparam int STREAM_LEN   = 200;
    localparam int STREAM_LIMIT = 40000;

    logic      clk;
    logic      rst;
    logic      wr_en;
    byte_t     wr_data;
    logic      rd_en;
    logic      miso;
    logic      tx_full;
    byte_t     rd_data;
    logic      rx_empty;
    fifo_cnt_t rx_level;
    logic      sclk;
    logic      mosi;
    logic      cs_n;

    byte_t exp_cap_q[$];   // Accepted writes in slave order
    byte_t exp_rd_q[$];    // Responses in host read order
    int    err_cnt;
    int    test_cnt;
    int    test_fail;
    int    err_base;

    spi_subsystem i_dut (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .tx_full  (tx_full),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .rx_empty (rx_empty),
        .rx_level (rx_level),
        .miso     (miso),
        .sclk     (sclk),
        .mosi     (mosi),
        .cs_n     (cs_n)
    );

    spi_slave_model i_slave (
        .sclk (sclk),
        .mosi (mosi),
        .cs_n (cs_n),
        .miso (miso)
    );

    bind spi_master spi_subsystem_assert i_assert (
        .clk      (clk),
        .rst      (rst),
        .state    (state),
        .tx_pop   (tx_pop),
        .tx_empty (tx_empty),
        .rx_full  (rx_full),
        .rx_push  (rx_push),
        .sclk     (sclk),
        .cs_n     (cs_n)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;     // 8 ns period
    end

    // ------------------------------------------------------------
    // Check and bookkeeping helpers
    // ------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        err_cnt++;
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        if (err_cnt == err_base) begin
            $display("Test %s: ok", name);
        end
        else begin
            test_fail++;
            $display("Test %s: FAILED", name);
        end
        err_base = err_cnt;
    endtask

    // Model side of an accepted write
    task automatic accept_write(input byte_t data, input byte_t resp);
        exp_cap_q.push_back(data);
        exp_rd_q.push_back(resp);
        i_slave.resp_q.push_back(resp);
    endtask

    task automatic check_head();
        if (exp_rd_q.size() == 0) begin
            report_problem("Host read a byte that no write asked for");
        end
        else begin
            check_value("rd_data", rd_data, exp_rd_q.pop_front());
        end
    endtask

    // ------------------------------------------------------------
    // Host strobes driven on the falling edge
    // ------------------------------------------------------------
    task automatic write_byte(input byte_t data, input byte_t resp, output logic taken);
        @(negedge clk);
        wr_en   = 1'b1;            // Left high for back to back writes
        wr_data = data;
        taken   = !tx_full;        // Full at this edge means dropped
        if (taken) begin
            accept_write(data, resp);
        end
    endtask

    task automatic release_strobes();
        @(negedge clk);
        wr_en = 1'b0;
        rd_en = 1'b0;
    endtask

    task automatic write_when_room(input byte_t data, input byte_t resp);
        int   n;
        logic taken;
        n = 0;
        while (tx_full && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        write_byte(data, resp, taken);
        release_strobes();
        if (!taken) begin
            report_problem("Transmit FIFO never had room for a write");
        end
    endtask

    task automatic read_byte();
        int n;
        n = 0;
        while (rx_empty && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rx_empty) begin
            report_problem("Timed out waiting for a received byte");
        end
        else begin
            check_head();
            rd_en = 1'b1;
            @(negedge clk);
            rd_en = 1'b0;
        end
    endtask

    task automatic drain_responses();
        int n;
        n = exp_rd_q.size();
        repeat (n) begin
            read_byte();
        end
    endtask

    // Slave captures against accepted writes in order
    task automatic check_captures();
        check_value("slave capture count", i_slave.cap_q.size(), exp_cap_q.size());
        while (i_slave.cap_q.size() > 0 && exp_cap_q.size() > 0) begin
            check_value("mosi byte", i_slave.cap_q.pop_front(), exp_cap_q.pop_front());
        end
        i_slave.cap_q.delete();
        exp_cap_q.delete();
        check_value("unread responses", exp_rd_q.size(), 0);
        exp_rd_q.delete();
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        logic  taken;
        logic  seen_full;
        int    n;
        int    accepted;
        int    cs_low;
        int    snap;
        byte_t resp;

        rst      = 1'b1;
        wr_en    = 1'b0;
        wr_data  = '0;
        rd_en    = 1'b0;
        err_cnt  = 0;
        test_cnt = 0;
        test_fail = 0;
        err_base = 0;
        void'($urandom(32'hd8b88b38));
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Idle pins and empty buffers
        @(negedge clk);
        check_value("sclk", sclk, 1);
        check_value("cs_n", cs_n, 1);
        check_value("mosi", mosi, 0);
        check_value("rx_empty", rx_empty, 1);
        check_value("tx_full", tx_full, 0);
        check_value("rx_level", rx_level, 0);
        finish_test("reset_state");

        write_byte(byte_t'($urandom), byte_t'($urandom), taken);
        release_strobes();
        read_byte();
        check_captures();
        finish_test("single_exchange");

        // An empty FIFO holds a whole burst
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            write_byte(byte_t'($urandom), byte_t'($urandom), taken);
            check_value("burst write taken", taken, 1);
        end
        release_strobes();
        drain_responses();
        check_captures();
        finish_test("burst_order");

        // Host silent so writes outrun the engine
        seen_full = 1'b0;
        for (int i = 0; i < FIFO_DEPTH + 4; i++) begin
            write_byte(byte_t'($urandom), byte_t'($urandom), taken);
            if (!taken) begin
                seen_full = 1'b1;
            end
        end
        release_strobes();
        check_value("tx_full seen", seen_full, 1);
        drain_responses();
        check_captures();
        finish_test("tx_overflow");

        for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
            write_when_room(byte_t'($urandom), byte_t'($urandom));
        end
        n = 0;
        while (rx_level != FIFO_FULL_CNT && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rx_level != FIFO_FULL_CNT) begin
            report_problem("Receive FIFO never filled");
        end
        snap   = i_slave.cap_q.size();
        cs_low = 0;
        repeat (300) begin          // Engine must hold off
            @(negedge clk);
            if (!cs_n) begin
                cs_low++;
            end
        end
        check_value("cs_n low cycles", cs_low, 0);
        check_value("captures while stalled", i_slave.cap_q.size(), snap);
        drain_responses();
        check_captures();
        finish_test("rx_backpressure");

        accepted = 0;
        n = 0;
        while ((accepted < STREAM_LEN || exp_rd_q.size() > 0) && n < STREAM_LIMIT) begin
            @(negedge clk);
            n++;
            wr_en   = (accepted < STREAM_LEN) && ($urandom_range(3) == 0);
            wr_data = byte_t'($urandom);
            rd_en   = ($urandom_range(1) == 0);   // Also hits empty reads
            if (wr_en && !tx_full) begin
                resp = byte_t'($urandom);
                accept_write(wr_data, resp);
                accepted++;
            end
            if (rd_en && !rx_empty) begin
                check_head();
            end
        end
        release_strobes();
        if (accepted < STREAM_LEN || exp_rd_q.size() > 0) begin
            report_problem("Random stream did not finish in time");
        end
        check_captures();
        finish_test("random_stream");

        $display("Tests: %0d run, %0d failed, %0d errors", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end
        else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
src/spi_pkg.sv
src/byte_fifo.sv
src/spi_master.sv
src/spi_subsystem.sv
testbench/spi_subsystem_assert.sv
testbench/spi_slave_model.sv
testbench/tb_spi_subsystem.sv
